// File: tests/rom_loader_patterns.txt
# index ext file_addr exp_page exp_half exp_bank exp_writes, all hex
# ext holds the two extension characters as ASCII codes, so "1A" is 3141
# firmware slots 0-7, then two slots past the table
00 0000 0000000 00 0 0 1
00 0000 0004123 00 1 0 1
00 0000 0008200 07 1 0 1
00 0000 000ffff ff 0 0 1
00 0000 0010001 00 0 1 1
00 0000 0015555 00 1 1 1
00 0000 001a0f0 07 1 1 1
00 0000 001c00a ff 0 1 1
00 0000 0020000 00 0 0 0
00 0000 1ffc123 00 0 0 0
# extension pages "1A", "G5" and "ZZ"
80 3141 0000010 1a 1 0 1
80 3141 0004020 1b 1 0 1
80 4735 0000100 e5 1 0 1
80 5a5a 0002000 00 0 0 1
# index 01 duplicates into bank 1
01 3141 0000033 1a 1 0 2
# bank and duplication with "30"
40 3330 0000044 30 1 0 2
c0 3330 0000055 30 1 1 1
# combo "Z0", second file page moves to page 1FF and wraps
80 5a30 0003fff 00 0 0 1
80 5a30 0004000 00 1 0 1
80 5a30 0008abc 01 1 0 1

// File: flist.f
src/cpc_rom_pkg.sv
src/rom_ext_decode.sv
src/rom_slot_map.sv
src/rom_write_seq.sv
src/rom_loader_top.sv
tests/clk_gen.sv
tests/rom_loader_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the ROM loader testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --timescale 1ns/100ps -Wno-fatal --top-module rom_loader_tb \
	-f flist.f -o rom_loader_sim > build.log 2>&1 \
	|| { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/rom_loader_sim > sim.log 2>&1 || echo "Simulator returned an error"
cat sim.log
grep -qx "TEST PASSED" sim.log && echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

// File: tests/rom_loader_tb.sv
// Testbench for the ROM download loader, replays the pattern file and checks memory writes
module rom_loader_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int WAIT_LIMIT   = 64;   // Cycles per wait loop
	localparam int QUIET_CYCLES = 32;   // Watch window for a dropped byte

	logic                    clk_sys;
	logic                    reset;
	logic                    dl_active;
	cpc_rom_pkg::byte_t      dl_index;
	logic [15:0]             dl_file_ext;
	logic                    dl_wr;
	logic [24:0]             dl_addr;
	cpc_rom_pkg::byte_t      dl_data;
	logic                    dl_wait;
	logic                    mem_we;
	cpc_rom_pkg::boot_addr_u mem_addr;
	cpc_rom_pkg::bank_t      mem_bank;
	cpc_rom_pkg::byte_t      mem_data;
	logic [255:0]            rom_map;

	logic                    prev_we;
	cpc_rom_pkg::boot_addr_u wr_addr_q[$];
	cpc_rom_pkg::bank_t      wr_bank_q[$];
	cpc_rom_pkg::byte_t      wr_data_q[$];
	logic [255:0]            exp_map;   // Upper pages written so far
	int                      value_errors;
	int                      other_failures;

	clk_gen clk_gen_inst (
		.clk_sys (clk_sys),
		.reset   (reset)
	);

	rom_loader_top rom_loader_top_inst (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.dl_active   (dl_active),
		.dl_index    (dl_index),
		.dl_file_ext (dl_file_ext),
		.dl_wr       (dl_wr),
		.dl_addr     (dl_addr),
		.dl_data     (dl_data),
		.dl_wait     (dl_wait),
		.mem_we      (mem_we),
		.mem_addr    (mem_addr),
		.mem_bank    (mem_bank),
		.mem_data    (mem_data),
		.rom_map     (rom_map)
	);

	////////////////////////////////////////
	// Write monitor, one entry per rise of mem_we

	always @(negedge clk_sys) begin
		prev_we <= mem_we;
		if (mem_we && !prev_we) begin
			wr_addr_q.push_back(mem_addr);
			wr_bank_q.push_back(mem_bank);
			wr_data_q.push_back(mem_data);
		end
	end

	////////////////////////////////////////
	// Compare tasks

	task automatic check_addr(input cpc_rom_pkg::boot_addr_u got,
	                          input cpc_rom_pkg::boot_addr_u exp, input string what);
		if (got !== exp) begin
			value_errors++;
			$display("Error at %0d ns: %s address %h, expected %h", $time, what, got.flat, exp.flat);
		end
	endtask

	task automatic check_bank(input cpc_rom_pkg::bank_t got, input cpc_rom_pkg::bank_t exp,
	                          input string what);
		if (got !== exp) begin
			value_errors++;
			$display("Error at %0d ns: %s bank %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_data(input cpc_rom_pkg::byte_t got, input cpc_rom_pkg::byte_t exp,
	                          input string what);
		if (got !== exp) begin
			value_errors++;
			$display("Error at %0d ns: %s data %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			value_errors++;
			$display("Error at %0d ns: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_map(input logic [255:0] got, input logic [255:0] exp, input string what);
		if (got !== exp) begin
			value_errors++;
			$display("Error at %0d ns: %s ROM map %h, expected %h", $time, what, got, exp);
		end
	endtask

	////////////////////////////////////////
	// Host side

	// Bounded wait for dl_wait to reach a level
	task automatic wait_for_wait(input logic level, input string what);
		int cycles;
		cycles = 0;
		while (dl_wait !== level && cycles < WAIT_LIMIT) begin
			@(negedge clk_sys);
			cycles++;
		end
		if (dl_wait !== level) begin
			other_failures++;
			$display("Timeout: %s within %0d cycles", what, WAIT_LIMIT);
		end
	endtask

	// Drop dl_active, then restart with a new index and extension
	task automatic start_session(input cpc_rom_pkg::byte_t idx, input logic [15:0] ext);
		@(posedge clk_sys);
		#2 dl_active = 1'b0;
		@(posedge clk_sys);
		#2;
		dl_index    = idx;
		dl_file_ext = ext;
		dl_active   = 1'b1;
		repeat (2) @(posedge clk_sys);
	endtask

	task automatic send_byte(input logic [24:0] addr, input cpc_rom_pkg::byte_t data);
		@(posedge clk_sys);
		#2;
		dl_addr = addr;
		dl_data = data;
		dl_wr   = 1'b1;
		@(posedge clk_sys);
		#2 dl_wr = 1'b0;
	endtask

	task automatic run_op(input logic [24:0] addr, input logic [7:0] pg, input logic half,
	                      input cpc_rom_pkg::bank_t bank, input int nwr,
	                      input cpc_rom_pkg::byte_t data, input int line_no);
		cpc_rom_pkg::boot_addr_u exp_addr;
		string                   what;
		int                      i;
		logic                    rose;
		exp_addr.f.hi_half = half;
		exp_addr.f.page    = pg;
		exp_addr.f.offset  = addr[13:0];
		what = $sformatf("line %0d", line_no);
		rose = 1'b0;
		wr_addr_q.delete();
		wr_bank_q.delete();
		wr_data_q.delete();
		send_byte(addr, data);
		if (nwr == 0) begin
			repeat (QUIET_CYCLES) begin
				@(negedge clk_sys);
				rose = rose | (dl_wait !== 1'b0);
			end
			if (rose) begin
				other_failures++;
				$display("dl_wait went high for a byte outside the firmware slots (%s)", what);
			end
		end else begin
			wait_for_wait(1'b1, "dl_wait never rose");
			wait_for_wait(1'b0, "dl_wait never fell");
			if (half) begin
				exp_map[pg] = 1'b1;
			end
		end
		if (wr_addr_q.size() != nwr) begin
			value_errors++;
			$display("Error at %0d ns: %s gave %0d writes, expected %0d",
			         $time, what, wr_addr_q.size(), nwr);
		end else begin
			for (i = 0; i < nwr; i++) begin
				check_addr(wr_addr_q[i], exp_addr, what);
				check_bank(wr_bank_q[i], (i == 0) ? bank : 2'd1, what);  // Repeat lands in bank 1
				check_data(wr_data_q[i], data, what);
			end
		end
		check_map(rom_map, exp_map, what);
	endtask

	////////////////////////////////////////
	// Main sequence

	initial begin
		int                 fd;
		int                 n;
		int                 cycles;
		int                 line_no;
		int                 ops;
		string              line;
		logic [31:0]        rnd;
		logic [7:0]         idx;
		logic [15:0]        ext;
		logic [24:0]        addr;
		logic [7:0]         pg;
		logic               half;
		cpc_rom_pkg::bank_t bank;
		int                 nwr;
		logic [7:0]         cur_idx;
		logic [15:0]        cur_ext;
		logic               in_session;
		dl_active      = 1'b0;
		dl_index       = '0;
		dl_file_ext    = '0;
		dl_wr          = 1'b0;
		dl_addr        = '0;
		dl_data        = '0;
		value_errors   = 0;
		other_failures = 0;
		exp_map        = '0;
		in_session     = 1'b0;
		line_no        = 0;
		ops            = 0;
		cur_idx        = '0;
		cur_ext        = '0;
		rnd = $urandom(62);   // Seed the generator

		// Outputs while reset is held
		@(posedge clk_sys);
		@(negedge clk_sys);
		check_bit(dl_wait, 1'b0, "dl_wait in reset");
		check_bit(mem_we, 1'b0, "mem_we in reset");
		check_map(rom_map, '0, "reset");
		cycles = 0;
		while (reset !== 1'b0 && cycles < WAIT_LIMIT) begin
			@(negedge clk_sys);
			cycles++;
		end
		if (reset !== 1'b0) begin
			other_failures++;
			$display("Timeout: reset was never released");
		end

		fd = $fopen("tests/rom_loader_patterns.txt", "r");
		if (fd == 0) begin
			other_failures++;
			$display("Could not open the pattern file tests/rom_loader_patterns.txt");
		end else begin
			while (!$feof(fd)) begin
				n = $fgets(line, fd);
				line_no++;
				if (n > 0 && line.len() > 0 && line[0] != "#") begin
					n = $sscanf(line, "%h %h %h %h %h %h %h", idx, ext, addr, pg, half, bank, nwr);
					if (n == 7) begin
						rnd = $urandom;
						if (!in_session || idx != cur_idx || ext != cur_ext) begin
							start_session(idx, ext);
							cur_idx    = idx;
							cur_ext    = ext;
							in_session = 1'b1;
						end
						run_op(addr, pg, half, bank, nwr, rnd[7:0], line_no);
						ops++;
					end
				end
			end
			$fclose(fd);
		end
		if (ops == 0) begin
			other_failures++;
			$display("The pattern file held no operations");
		end

		$display("Checks done: %0d value errors, %0d other failures", value_errors, other_failures);
		if (value_errors == 0 && other_failures == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// File: tests/clk_gen.sv
// Testbench clock and reset source, 20 ns clock with reset held for five cycles
module clk_gen (
	output logic clk_sys,
	output logic reset
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int RESET_CYCLES = 5;

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		#2 reset = 1'b0;   // Released just after the fifth edge
	end

endmodule

// File: src/rom_loader_top.sv
// ROM download loader that moves host download bytes into the shared memory
module rom_loader_top (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    dl_active,
	input  cpc_rom_pkg::byte_t      dl_index,
	input  logic [15:0]             dl_file_ext,
	input  logic                    dl_wr,
	input  logic [24:0]             dl_addr,
	input  cpc_rom_pkg::byte_t      dl_data,
	output logic                    dl_wait,
	output logic                    mem_we,
	output cpc_rom_pkg::boot_addr_u mem_addr,
	output cpc_rom_pkg::bank_t      mem_bank,
	output cpc_rom_pkg::byte_t      mem_data,
	output logic [255:0]            rom_map
);

	cpc_rom_pkg::page_t      base_page;
	logic                    byte_load;
	logic                    slot_valid;
	cpc_rom_pkg::boot_addr_u load_addr;
	cpc_rom_pkg::bank_t      load_bank;
	cpc_rom_pkg::byte_t      load_data;
	logic                    load_dup;
	logic                    page_done;

	////////////////////////////////////////
	// Extension decode

	rom_ext_decode rom_ext_decode_inst (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.dl_active    (dl_active),
		.dl_index     (dl_index),
		.dl_file_ext  (dl_file_ext),
		.page_done    (page_done),
		.base_page    (base_page),
		.combo_active ()
	);

	////////////////////////////////////////
	// Slot and address mapping

	rom_slot_map rom_slot_map_inst (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.dl_active  (dl_active),
		.dl_index   (dl_index),
		.dl_wr      (dl_wr),
		.dl_addr    (dl_addr),
		.dl_data    (dl_data),
		.base_page  (base_page),
		.byte_load  (byte_load),
		.slot_valid (slot_valid),
		.load_addr  (load_addr),
		.load_bank  (load_bank),
		.load_data  (load_data),
		.load_dup   (load_dup)
	);

	////////////////////////////////////////
	// Memory write and ROM map

	rom_write_seq rom_write_seq_inst (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.byte_load  (byte_load),
		.slot_valid (slot_valid),
		.load_addr  (load_addr),
		.load_bank  (load_bank),
		.load_data  (load_data),
		.load_dup   (load_dup),
		.dl_wait    (dl_wait),
		.mem_we     (mem_we),
		.mem_addr   (mem_addr),
		.mem_bank   (mem_bank),
		.mem_data   (mem_data),
		.rom_map    (rom_map),
		.page_done  (page_done)
	);

endmodule

// File: src/rom_write_seq.sv
// ROM write sequencer, paces memory writes on the clock enable and keeps the ROM map
module rom_write_seq (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    byte_load,
	input  logic                    slot_valid,
	input  cpc_rom_pkg::boot_addr_u load_addr,
	input  cpc_rom_pkg::bank_t      load_bank,
	input  cpc_rom_pkg::byte_t      load_data,
	input  logic                    load_dup,
	output logic                    dl_wait,
	output logic                    mem_we,
	output cpc_rom_pkg::boot_addr_u mem_addr,
	output cpc_rom_pkg::bank_t      mem_bank,
	output cpc_rom_pkg::byte_t      mem_data,
	output logic [255:0]            rom_map,
	output logic                    page_done
);

	logic [cpc_rom_pkg::CE_DIV_W-1:0] ce_div;
	logic                             ce;
	logic                             wr_dup;  // Repeat into bank 1 pending

	////////////////////////////////////////
	// Clock enable

	always_ff @(posedge clk_sys) begin
		ce_div <= ce_div + 1'd1;
		ce     <= (ce_div == '0);

		if (reset) begin
			ce_div <= '0;
			ce     <= 1'b0;
		end
	end

	////////////////////////////////////////
	// Write sequencing

	always_ff @(posedge clk_sys) begin
		page_done <= 1'b0;

		// New byte, host is held until it is stored
		if (byte_load && slot_valid) begin
			dl_wait  <= 1'b1;
			mem_addr <= load_addr;
			mem_bank <= load_bank;
			mem_data <= load_data;
			wr_dup   <= load_dup;
		end

		if (ce) begin
			mem_we <= dl_wait;
			if (mem_we && dl_wait) begin
				mem_we <= 1'b0;
				if (wr_dup && (mem_bank == '0)) begin
					mem_bank <= 2'd1;  // Same byte again, other bank
				end else begin
					dl_wait <= 1'b0;
					if (mem_addr.f.hi_half) begin
						rom_map[mem_addr.f.page] <= 1'b1;
					end
					// Last byte of the page
					page_done <= &mem_addr.f.offset;
				end
			end
		end

		if (reset) begin
			dl_wait   <= 1'b0;
			mem_we    <= 1'b0;
			page_done <= 1'b0;
			rom_map   <= '0;
		end
	end

endmodule

// File: src/rom_slot_map.sv
// ROM slot mapper, registers each host byte with its target address and bank
module rom_slot_map (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    dl_active,
	input  cpc_rom_pkg::byte_t      dl_index,
	input  logic                    dl_wr,
	input  logic [24:0]             dl_addr,
	input  cpc_rom_pkg::byte_t      dl_data,
	input  cpc_rom_pkg::page_t      base_page,
	output logic                    byte_load,
	output logic                    slot_valid,
	output cpc_rom_pkg::boot_addr_u load_addr,
	output cpc_rom_pkg::bank_t      load_bank,
	output cpc_rom_pkg::byte_t      load_data,
	output logic                    load_dup
);

	logic                    rom_download;
	logic [10:0]             fw_slot;
	cpc_rom_pkg::boot_addr_u next_addr;
	cpc_rom_pkg::bank_t      next_bank;
	logic                    next_valid;
	logic                    next_dup;

	assign rom_download = dl_active && (dl_index[4:0] < cpc_rom_pkg::ROM_INDEX_LIMIT);
	assign fw_slot      = dl_addr[24:14];  // 16 KB slot in the firmware image

	////////////////////////////////////////
	// Target selection

	always_comb begin
		next_addr  = '0;
		next_bank  = '0;
		next_valid = 1'b1;
		next_dup   = 1'b0;

		if (dl_index == '0) begin
			// Firmware image, fixed page per slot
			case (fw_slot)
				11'd0, 11'd4: next_addr.flat = {cpc_rom_pkg::PAGE_OS, dl_addr[13:0]};
				11'd1, 11'd5: next_addr.flat = {cpc_rom_pkg::PAGE_BASIC, dl_addr[13:0]};
				11'd2, 11'd6: next_addr.flat = {cpc_rom_pkg::PAGE_AMSDOS, dl_addr[13:0]};
				11'd3, 11'd7: next_addr.flat = {cpc_rom_pkg::PAGE_MF2, dl_addr[13:0]};
				default:      next_valid = 1'b0;  // Past the last slot
			endcase

			// Second model in slots 4-7
			if (fw_slot[2]) begin
				next_bank = 2'd1;
			end
		end else begin
			next_addr.f.hi_half = base_page[8];
			next_addr.f.page    = base_page[7:0] + dl_addr[21:14];  // Wraps at 8 bits
			next_addr.f.offset  = dl_addr[13:0];
			next_bank           = {1'b0, &dl_index[7:6]};

			// Manual load or boot name also goes into bank 1
			next_dup = ((dl_index[7:6] == 2'b01) || (dl_index[5:0] != '0))
			           && (next_bank == '0);
		end
	end

	////////////////////////////////////////
	// Byte capture

	always_ff @(posedge clk_sys) begin
		byte_load <= rom_download && dl_wr;

		if (rom_download && dl_wr) begin
			slot_valid <= next_valid;
			load_addr  <= next_addr;
			load_bank  <= next_bank;
			load_data  <= dl_data;
			load_dup   <= next_dup;
		end

		if (reset) begin
			byte_load  <= 1'b0;
			slot_valid <= 1'b0;
		end
	end

endmodule

// File: src/rom_ext_decode.sv
// Expansion ROM extension decoder, turns the file extension into a base page
module rom_ext_decode (
	input  logic                clk_sys,
	input  logic                reset,
	input  logic                dl_active,
	input  cpc_rom_pkg::byte_t  dl_index,
	input  logic [15:0]         dl_file_ext,
	input  logic                page_done,
	output cpc_rom_pkg::page_t  base_page,
	output logic                combo_active
);

	// One hex character to a nibble, keeps the fallback otherwise
	function automatic logic [3:0] char_nibble(input cpc_rom_pkg::byte_t ch,
	                                           input logic [3:0] fallback);
		logic [3:0] nib;
		nib = fallback;
		if (ch >= "0" && ch <= "9") begin
			nib = ch[3:0];
		end else if (ch >= "A" && ch <= "F") begin
			nib = ch[3:0] + 4'd9;   // 'A' has low nibble 1
		end
		return nib;
	endfunction

	logic               old_active;
	logic               rom_download;
	logic               dl_start;
	cpc_rom_pkg::page_t parsed_page;
	logic               parsed_combo;

	assign rom_download = dl_active && (dl_index[4:0] < cpc_rom_pkg::ROM_INDEX_LIMIT);
	assign dl_start     = rom_download && !old_active && (dl_index != '0);

	////////////////////////////////////////
	// Extension parsing

	always_comb begin
		parsed_page  = cpc_rom_pkg::PAGE_BAD_EXT;
		parsed_combo = 1'b0;
		parsed_page[7:4] = char_nibble(dl_file_ext[15:8], parsed_page[7:4]);
		parsed_page[3:0] = char_nibble(dl_file_ext[7:0], parsed_page[3:0]);

		if (dl_file_ext == "ZZ") begin
			parsed_page = '0;
		end
		if (dl_file_ext == "Z0") begin  // Combo image, two pages
			parsed_page  = '0;
			parsed_combo = 1'b1;
		end
	end

	////////////////////////////////////////
	// Base page register

	always_ff @(posedge clk_sys) begin
		old_active <= dl_active;

		// First page of a combo is full, move on
		if (page_done && combo_active) begin
			base_page    <= cpc_rom_pkg::PAGE_COMBO_NEXT;
			combo_active <= 1'b0;
		end

		if (dl_start) begin
			base_page    <= parsed_page;
			combo_active <= parsed_combo;
		end

		if (reset) begin
			old_active   <= 1'b0;
			combo_active <= 1'b0;
		end
	end

endmodule

// File: src/cpc_rom_pkg.sv
// ROM loader package with memory geometry, fixed ROM pages and boot address type
package cpc_rom_pkg;

	////////////////////////////////////////
	// Sizes and widths

	localparam int OFFSET_W = 14;       // Byte offset inside a 16 KB page
	localparam int PAGE_W   = 8;        // Page number inside one memory half
	localparam int ADDR_W   = 23;       // Full memory address
	localparam int CE_DIV_W = 3;        // Clock enable every 8 clocks

	// Indices below this (bits 4..0) are ROM downloads
	localparam int ROM_INDEX_LIMIT = 4;

	////////////////////////////////////////
	// Types

	typedef logic [7:0] byte_t;
	typedef logic [PAGE_W:0] page_t;    // Half bit on top of the page
	typedef logic [1:0] bank_t;

	// Boot address, either one flat word or half/page/offset
	typedef union packed {
		logic [ADDR_W-1:0] flat;
		struct packed {
			logic                hi_half;  // Upper 4 MB holds expansion ROMs
			logic [PAGE_W-1:0]   page;
			logic [OFFSET_W-1:0] offset;
		} f;
	} boot_addr_u;

	////////////////////////////////////////
	// Page numbers

	// Firmware pages in the lower half, except BASIC and AMSDOS
	localparam page_t PAGE_OS     = 9'h000;
	localparam page_t PAGE_BASIC  = 9'h100;
	localparam page_t PAGE_AMSDOS = 9'h107;
	localparam page_t PAGE_MF2    = 9'h0FF;  // Freeze cartridge ROM

	localparam page_t PAGE_BAD_EXT    = 9'h1EE; // Unused page, malformed extension
	localparam page_t PAGE_COMBO_NEXT = 9'h1FF; // Second part of a combo image

endpackage
